// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/cache_manage.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mem_defs.svh"

module cache_manage (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    ireq_valid,
    input  wire [`MEM_ADDR_W-1:0]  ireq_addr,
    output logic                   iresp_addr_ok,
    output logic                   iresp_data_ok,
    output logic [`MEM_DATA_W-1:0] iresp_data,
    input  wire                    d1_req_valid,
    input  wire mem_pkg::mem_op_e  d1_req_op,
    input  wire [`MEM_ADDR_W-1:0]  d1_req_addr,
    input  wire [`MEM_DATA_W-1:0]  d1_req_wdata,
    output logic                   d1_addr_ok,
    output logic                   d1_data_ok,
    output logic [`MEM_DATA_W-1:0] d1_data,
    input  wire                    d2_req_valid,
    input  wire mem_pkg::mem_op_e  d2_req_op,
    input  wire [`MEM_ADDR_W-1:0]  d2_req_addr,
    input  wire [`MEM_DATA_W-1:0]  d2_req_wdata,
    output logic                   d2_addr_ok,
    output logic                   d2_data_ok,
    output logic [`MEM_DATA_W-1:0] d2_data,
    output logic                   ic_req_valid,
    output logic [`MEM_ADDR_W-1:0] ic_req_addr,
    input  wire                    ic_addr_ok,
    input  wire                    ic_data_ok,
    input  wire [`MEM_DATA_W-1:0]  ic_data,
    output logic                   dc_req_valid,
    output mem_pkg::mem_op_e       dc_req_op,
    output logic [`MEM_ADDR_W-1:0] dc_req_addr,
    output logic [`MEM_DATA_W-1:0] dc_req_wdata,
    input  wire                    dc_addr_ok,
    input  wire                    dc_data_ok,
    input  wire [`MEM_DATA_W-1:0]  dc_data,
    output logic                   u1_req_valid,
    output mem_pkg::mem_op_e       u1_req_op,
    output logic [`MEM_ADDR_W-1:0] u1_req_addr,
    output logic [`MEM_DATA_W-1:0] u1_req_wdata,
    input  wire                    u1_addr_ok,
    input  wire                    u1_data_ok,
    input  wire [`MEM_DATA_W-1:0]  u1_data,
    output logic                   u2_req_valid,
    output mem_pkg::mem_op_e       u2_req_op,
    output logic [`MEM_ADDR_W-1:0] u2_req_addr,
    output logic [`MEM_DATA_W-1:0] u2_req_wdata,
    input  wire                    u2_addr_ok,
    input  wire                    u2_data_ok,
    input  wire [`MEM_DATA_W-1:0]  u2_data
);

    logic d1_unc;
    logic d2_unc;
    logic d1_cached;
    logic d2_cached;
    logic dc_busy;
    logic dc_own2;
    logic dc_sel2;
    logic d1_unc_q;
    logic d1_dc_q;
    logic d2_unc_q;
    logic d2_dc_q;

    // fixed segment map, top three bits cleared
    function automatic logic [`MEM_ADDR_W-1:0] to_phys(input logic [`MEM_ADDR_W-1:0] vaddr);
        return {3'b000, vaddr[`MEM_ADDR_W-4:0]};
    endfunction

    assign ic_req_valid = ireq_valid;
    assign ic_req_addr = to_phys(ireq_addr);
    assign iresp_addr_ok = ic_addr_ok;
    assign iresp_data_ok = ic_data_ok;
    assign iresp_data = ic_data;

    assign d1_unc = d1_req_valid && d1_req_addr[`UNCACHE_BIT];
    assign d2_unc = d2_req_valid && d2_req_addr[`UNCACHE_BIT];
    assign d1_cached = d1_req_valid && !d1_req_addr[`UNCACHE_BIT];
    assign d2_cached = d2_req_valid && !d2_req_addr[`UNCACHE_BIT];

    // port 1 first; owner kept while the dcache works on a miss or write
    assign dc_sel2 = dc_busy ? dc_own2 : (!d1_cached && d2_cached);

    assign dc_req_valid = dc_sel2 ? d2_cached : d1_cached;
    assign dc_req_op = dc_sel2 ? d2_req_op : d1_req_op;
    assign dc_req_addr = to_phys(dc_sel2 ? d2_req_addr : d1_req_addr);
    assign dc_req_wdata = dc_sel2 ? d2_req_wdata : d1_req_wdata;

    assign u1_req_valid = d1_unc;
    assign u1_req_op = d1_req_op;
    assign u1_req_addr = to_phys(d1_req_addr);
    assign u1_req_wdata = d1_req_wdata;

    assign u2_req_valid = d2_unc;
    assign u2_req_op = d2_req_op;
    assign u2_req_addr = to_phys(d2_req_addr);
    assign u2_req_wdata = d2_req_wdata;

    assign d1_addr_ok = d1_unc ? u1_addr_ok : (d1_cached && !dc_sel2 && dc_addr_ok);
    assign d2_addr_ok = d2_unc ? u2_addr_ok : (d2_cached && dc_sel2 && dc_addr_ok);

    always_ff @(posedge clk) begin
        if (resetn) begin
            dc_busy <= 1'b0;
            dc_own2 <= 1'b0;
            d1_unc_q <= 1'b0;
            d1_dc_q <= 1'b0;
            d2_unc_q <= 1'b0;
            d2_dc_q <= 1'b0;
        end else begin
            if (dc_addr_ok) begin
                dc_busy <= 1'b0;
            end else if (dc_req_valid) begin
                dc_busy <= 1'b1;
                dc_own2 <= dc_sel2;
            end
            // path each port was accepted on
            d1_unc_q <= d1_addr_ok && d1_unc;
            d1_dc_q <= d1_addr_ok && !d1_unc;
            d2_unc_q <= d2_addr_ok && d2_unc;
            d2_dc_q <= d2_addr_ok && !d2_unc;
        end
    end

    assign d1_data_ok = (d1_unc_q && u1_data_ok) || (d1_dc_q && dc_data_ok);
    assign d1_data = d1_unc_q ? u1_data : dc_data;
    assign d2_data_ok = (d2_unc_q && u2_data_ok) || (d2_dc_q && dc_data_ok);
    assign d2_data = d2_unc_q ? u2_data : dc_data;

endmodule

`default_nettype wire

// ==== design/cbus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mem_defs.svh"

module cbus_arbiter #(
    parameter int NUM_MASTERS = 4
) (
    input  wire                                      clk,
    input  wire                                      resetn,
    input  wire [NUM_MASTERS-1:0]                    mreq_valid,
    input  wire [NUM_MASTERS-1:0]                    mreq_op,
    input  wire [NUM_MASTERS-1:0][`MEM_ADDR_W-1:0]   mreq_addr,
    input  wire [NUM_MASTERS-1:0][`MEM_DATA_W-1:0]   mreq_wdata,
    output logic [NUM_MASTERS-1:0]                   mresp_ready,
    output logic [`MEM_DATA_W-1:0]                   mresp_data,
    output logic                                     creq_valid,
    output mem_pkg::mem_op_e                         creq_op,
    output logic [`MEM_ADDR_W-1:0]                   creq_addr,
    output logic [`MEM_DATA_W-1:0]                   creq_wdata,
    input  wire                                      cresp_ready,
    input  wire [`MEM_DATA_W-1:0]                    cresp_data
);

    logic                 locked;
    mem_pkg::bus_master_e gnt_q;
    mem_pkg::bus_master_e pick;
    mem_pkg::bus_master_e gnt;

    // lowest index wins
    always_comb begin
        pick = mem_pkg::M_ICACHE;
        for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
            if (mreq_valid[i])
                pick = mem_pkg::bus_master_e'(2'(i));
        end
    end

    assign gnt = locked ? gnt_q : pick;

    assign creq_valid = mreq_valid[gnt];
    assign creq_op = mem_pkg::mem_op_e'(mreq_op[gnt]);
    assign creq_addr = mreq_addr[gnt];
    assign creq_wdata = mreq_wdata[gnt];
    assign mresp_data = cresp_data;

    always_comb begin
        mresp_ready = '0;
        mresp_ready[gnt] = cresp_ready && creq_valid;
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            locked <= 1'b0;
            gnt_q <= mem_pkg::M_DUNC1;
        end else if (locked) begin
            if (cresp_ready)
                locked <= 1'b0;
        end else if (creq_valid && !cresp_ready) begin
            // hold the winner for the whole transfer
            locked <= 1'b1;
            gnt_q <= pick;
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mem_defs.svh"

module dcache (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    req_valid,
    input  wire mem_pkg::mem_op_e  req_op,
    input  wire [`MEM_ADDR_W-1:0]  req_addr,
    input  wire [`MEM_DATA_W-1:0]  req_wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic [`MEM_DATA_W-1:0] data,
    output logic                   creq_valid,
    output mem_pkg::mem_op_e       creq_op,
    output logic [`MEM_ADDR_W-1:0] creq_addr,
    output logic [`MEM_DATA_W-1:0] creq_wdata,
    input  wire                    cresp_ready,
    input  wire [`MEM_DATA_W-1:0]  cresp_data
);

    localparam int IDX_W = $clog2(`DCACHE_LINES);
    localparam int TAG_W = `MEM_ADDR_W - IDX_W - 2;

    mem_pkg::cache_state_e    state;
    logic [TAG_W-1:0]         tag_arr [`DCACHE_LINES];
    logic [`MEM_DATA_W-1:0]   data_arr [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0] valid_arr;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             hit;
    logic             rd_hit;
    logic             fill_done;
    logic             wr_done;

    assign idx = req_addr[IDX_W+1:2];
    assign tag = req_addr[`MEM_ADDR_W-1:IDX_W+2];
    assign hit = valid_arr[idx] && (tag_arr[idx] == tag);

    assign rd_hit = (state == mem_pkg::ST_IDLE) && req_valid
                 && (req_op == mem_pkg::OP_READ) && hit;
    assign fill_done = (state == mem_pkg::ST_FILL) && cresp_ready;
    assign wr_done = (state == mem_pkg::ST_WRITE) && cresp_ready;

    assign addr_ok = rd_hit || fill_done || wr_done;
    assign creq_valid = (state == mem_pkg::ST_FILL) || (state == mem_pkg::ST_WRITE);
    assign creq_op = mem_pkg::mem_op_e'(state == mem_pkg::ST_WRITE);
    assign creq_addr = {req_addr[`MEM_ADDR_W-1:2], 2'b00};
    assign creq_wdata = req_wdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= mem_pkg::ST_IDLE;
            valid_arr <= '0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok;
            case (state)
                mem_pkg::ST_IDLE: begin
                    // every write goes to memory, hit or not
                    if (req_valid && (req_op == mem_pkg::OP_WRITE))
                        state <= mem_pkg::ST_WRITE;
                    else if (req_valid && !hit)
                        state <= mem_pkg::ST_FILL;
                end
                mem_pkg::ST_FILL: begin
                    if (cresp_ready) begin
                        valid_arr[idx] <= 1'b1;
                        state <= mem_pkg::ST_DONE;
                    end
                end
                mem_pkg::ST_WRITE: begin
                    if (cresp_ready)
                        state <= mem_pkg::ST_DONE;
                end
                default: state <= mem_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_arr[idx] <= tag;
            data_arr[idx] <= cresp_data;
        end else if (wr_done && hit) begin
            // no allocate on a write miss
            data_arr[idx] <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done)
            data <= cresp_data;
        else if (rd_hit)
            data <= data_arr[idx];
    end

endmodule

`default_nettype wire

// ==== design/icache.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mem_defs.svh"

module icache (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    req_valid,
    input  wire [`MEM_ADDR_W-1:0]  req_addr,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic [`MEM_DATA_W-1:0] data,
    output logic                   creq_valid,
    output logic [`MEM_ADDR_W-1:0] creq_addr,
    input  wire                    cresp_ready,
    input  wire [`MEM_DATA_W-1:0]  cresp_data
);

    localparam int IDX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W = `MEM_ADDR_W - IDX_W - 2;

    mem_pkg::cache_state_e    state;
    logic [TAG_W-1:0]         tag_arr [`ICACHE_LINES];
    logic [`MEM_DATA_W-1:0]   data_arr [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid_arr;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             hit;
    logic             fill_done;

    assign idx = req_addr[IDX_W+1:2];
    assign tag = req_addr[`MEM_ADDR_W-1:IDX_W+2];
    assign hit = valid_arr[idx] && (tag_arr[idx] == tag);
    assign fill_done = (state == mem_pkg::ST_FILL) && cresp_ready;

    // hit accepted at once, miss accepted when the fill word lands
    assign addr_ok = ((state == mem_pkg::ST_IDLE) && req_valid && hit) || fill_done;
    assign creq_valid = (state == mem_pkg::ST_FILL);
    assign creq_addr = {req_addr[`MEM_ADDR_W-1:2], 2'b00};

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= mem_pkg::ST_IDLE;
            valid_arr <= '0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok;
            case (state)
                mem_pkg::ST_IDLE: begin
                    if (req_valid && !hit)
                        state <= mem_pkg::ST_FILL;
                end
                mem_pkg::ST_FILL: begin
                    if (cresp_ready) begin
                        valid_arr[idx] <= 1'b1;
                        state <= mem_pkg::ST_DONE;
                    end
                end
                // response cycle of a fill
                default: state <= mem_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_arr[idx] <= tag;
            data_arr[idx] <= cresp_data;
            data <= cresp_data;
        end else if (addr_ok) begin
            data <= data_arr[idx];
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_WRITE,
        ST_DONE
    } cache_state_e;

    // arbiter inputs, highest priority first
    typedef enum logic [1:0] {
        M_DUNC1,
        M_DCACHE,
        M_DUNC2,
        M_ICACHE
    } bus_master_e;

endpackage

`default_nettype wire

// ==== design/mem_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mem_defs.svh"

module mem_subsys (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    ireq_valid,
    input  wire [`MEM_ADDR_W-1:0]  ireq_addr,
    output logic                   iresp_addr_ok,
    output logic                   iresp_data_ok,
    output logic [`MEM_DATA_W-1:0] iresp_data,
    input  wire                    d1_req_valid,
    input  wire mem_pkg::mem_op_e  d1_req_op,
    input  wire [`MEM_ADDR_W-1:0]  d1_req_addr,
    input  wire [`MEM_DATA_W-1:0]  d1_req_wdata,
    output logic                   d1_addr_ok,
    output logic                   d1_data_ok,
    output logic [`MEM_DATA_W-1:0] d1_data,
    input  wire                    d2_req_valid,
    input  wire mem_pkg::mem_op_e  d2_req_op,
    input  wire [`MEM_ADDR_W-1:0]  d2_req_addr,
    input  wire [`MEM_DATA_W-1:0]  d2_req_wdata,
    output logic                   d2_addr_ok,
    output logic                   d2_data_ok,
    output logic [`MEM_DATA_W-1:0] d2_data,
    output logic                   creq_valid,
    output mem_pkg::mem_op_e       creq_op,
    output logic [`MEM_ADDR_W-1:0] creq_addr,
    output logic [`MEM_DATA_W-1:0] creq_wdata,
    input  wire                    cresp_ready,
    input  wire [`MEM_DATA_W-1:0]  cresp_data
);

    logic                   ic_req_valid;
    logic [`MEM_ADDR_W-1:0] ic_req_addr;
    logic                   ic_addr_ok;
    logic                   ic_data_ok;
    logic [`MEM_DATA_W-1:0] ic_data;

    logic                   dc_req_valid;
    mem_pkg::mem_op_e       dc_req_op;
    logic [`MEM_ADDR_W-1:0] dc_req_addr;
    logic [`MEM_DATA_W-1:0] dc_req_wdata;
    logic                   dc_addr_ok;
    logic                   dc_data_ok;
    logic [`MEM_DATA_W-1:0] dc_data;

    logic                   u1_req_valid;
    mem_pkg::mem_op_e       u1_req_op;
    logic [`MEM_ADDR_W-1:0] u1_req_addr;
    logic [`MEM_DATA_W-1:0] u1_req_wdata;
    logic                   u1_addr_ok;
    logic                   u1_data_ok;
    logic [`MEM_DATA_W-1:0] u1_data;

    logic                   u2_req_valid;
    mem_pkg::mem_op_e       u2_req_op;
    logic [`MEM_ADDR_W-1:0] u2_req_addr;
    logic [`MEM_DATA_W-1:0] u2_req_wdata;
    logic                   u2_addr_ok;
    logic                   u2_data_ok;
    logic [`MEM_DATA_W-1:0] u2_data;

    // arbiter side, indexed by bus master
    wire [3:0]                  m_valid;
    wire [3:0]                  m_op;
    wire [3:0][`MEM_ADDR_W-1:0] m_addr;
    wire [3:0][`MEM_DATA_W-1:0] m_wdata;
    wire [3:0]                  m_ready;
    wire [`MEM_DATA_W-1:0]      m_data;

    // icache only reads
    assign m_op[mem_pkg::M_ICACHE] = mem_pkg::OP_READ;
    assign m_wdata[mem_pkg::M_ICACHE] = '0;

    cache_manage cache_manage_i (.*);

    icache icache_i (
        .clk, .resetn,
        .req_valid(ic_req_valid), .req_addr(ic_req_addr),
        .addr_ok(ic_addr_ok), .data_ok(ic_data_ok), .data(ic_data),
        .creq_valid(m_valid[mem_pkg::M_ICACHE]), .creq_addr(m_addr[mem_pkg::M_ICACHE]),
        .cresp_ready(m_ready[mem_pkg::M_ICACHE]), .cresp_data(m_data)
    );

    dcache dcache_i (
        .clk, .resetn,
        .req_valid(dc_req_valid), .req_op(dc_req_op),
        .req_addr(dc_req_addr), .req_wdata(dc_req_wdata),
        .addr_ok(dc_addr_ok), .data_ok(dc_data_ok), .data(dc_data),
        .creq_valid(m_valid[mem_pkg::M_DCACHE]), .creq_op(m_op[mem_pkg::M_DCACHE]),
        .creq_addr(m_addr[mem_pkg::M_DCACHE]), .creq_wdata(m_wdata[mem_pkg::M_DCACHE]),
        .cresp_ready(m_ready[mem_pkg::M_DCACHE]), .cresp_data(m_data)
    );

    uncache_bridge unc1 (
        .clk, .resetn,
        .req_valid(u1_req_valid), .req_op(u1_req_op),
        .req_addr(u1_req_addr), .req_wdata(u1_req_wdata),
        .addr_ok(u1_addr_ok), .data_ok(u1_data_ok), .data(u1_data),
        .creq_valid(m_valid[mem_pkg::M_DUNC1]), .creq_op(m_op[mem_pkg::M_DUNC1]),
        .creq_addr(m_addr[mem_pkg::M_DUNC1]), .creq_wdata(m_wdata[mem_pkg::M_DUNC1]),
        .cresp_ready(m_ready[mem_pkg::M_DUNC1]), .cresp_data(m_data)
    );

    uncache_bridge unc2 (
        .clk, .resetn,
        .req_valid(u2_req_valid), .req_op(u2_req_op),
        .req_addr(u2_req_addr), .req_wdata(u2_req_wdata),
        .addr_ok(u2_addr_ok), .data_ok(u2_data_ok), .data(u2_data),
        .creq_valid(m_valid[mem_pkg::M_DUNC2]), .creq_op(m_op[mem_pkg::M_DUNC2]),
        .creq_addr(m_addr[mem_pkg::M_DUNC2]), .creq_wdata(m_wdata[mem_pkg::M_DUNC2]),
        .cresp_ready(m_ready[mem_pkg::M_DUNC2]), .cresp_data(m_data)
    );

    cbus_arbiter cbus_arbiter_i (
        .clk, .resetn,
        .mreq_valid(m_valid), .mreq_op(m_op),
        .mreq_addr(m_addr), .mreq_wdata(m_wdata),
        .mresp_ready(m_ready), .mresp_data(m_data),
        .creq_valid, .creq_op, .creq_addr, .creq_wdata,
        .cresp_ready, .cresp_data
    );

endmodule

`default_nettype wire

// ==== design/uncache_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mem_defs.svh"

module uncache_bridge (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    req_valid,
    input  wire mem_pkg::mem_op_e  req_op,
    input  wire [`MEM_ADDR_W-1:0]  req_addr,
    input  wire [`MEM_DATA_W-1:0]  req_wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic [`MEM_DATA_W-1:0] data,
    output logic                   creq_valid,
    output mem_pkg::mem_op_e       creq_op,
    output logic [`MEM_ADDR_W-1:0] creq_addr,
    output logic [`MEM_DATA_W-1:0] creq_wdata,
    input  wire                    cresp_ready,
    input  wire [`MEM_DATA_W-1:0]  cresp_data
);

    // core holds the request until addr_ok, so it can drive the bus directly
    assign creq_valid = req_valid;
    assign creq_op = req_op;
    assign creq_addr = req_addr;
    assign creq_wdata = req_wdata;

    // accepted when the bus transfer completes
    assign addr_ok = req_valid && cresp_ready;

    always_ff @(posedge clk) begin
        if (resetn)
            data_ok <= 1'b0;
        else
            data_ok <= addr_ok;
    end

    always_ff @(posedge clk) begin
        if (addr_ok)
            data <= cresp_data;
    end

endmodule

`default_nettype wire

// ==== dv/cbus_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mem_defs.svh"

module cbus_mem_model #(
    parameter int LATENCY = 3
) (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    creq_valid,
    input  wire mem_pkg::mem_op_e  creq_op,
    input  wire [`MEM_ADDR_W-1:0]  creq_addr,
    input  wire [`MEM_DATA_W-1:0]  creq_wdata,
    output logic                   cresp_ready,
    output logic [`MEM_DATA_W-1:0] cresp_data,
    output int                     read_count
);

    logic [`MEM_DATA_W-1:0] mem [logic [`MEM_ADDR_W-1:0]];
    int                     wait_cnt;

    // words never written read back a pattern of their own address
    function automatic logic [`MEM_DATA_W-1:0] fill_word(input logic [`MEM_ADDR_W-1:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    always @(posedge clk) begin
        if (resetn) begin
            wait_cnt <= 0;
            cresp_ready <= 1'b0;
            cresp_data <= '0;
            read_count <= 0;
        end else begin
            cresp_ready <= 1'b0;
            if (creq_valid && !cresp_ready) begin
                if (wait_cnt == LATENCY - 1) begin
                    wait_cnt <= 0;
                    cresp_ready <= 1'b1;
                    if (creq_op == mem_pkg::OP_WRITE) begin
                        mem[creq_addr] = creq_wdata;
                    end else begin
                        cresp_data <= mem.exists(creq_addr) ? mem[creq_addr]
                                                            : fill_word(creq_addr);
                        read_count <= read_count + 1;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end else begin
                wait_cnt <= 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_mem_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mem_defs.svh"

module tb_mem_subsys;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MIX_ACCESSES = 130;

    logic                   clk;
    logic                   resetn;
    logic                   ireq_valid;
    logic [`MEM_ADDR_W-1:0] ireq_addr;
    logic                   iresp_addr_ok;
    logic                   iresp_data_ok;
    logic [`MEM_DATA_W-1:0] iresp_data;
    logic                   d1_req_valid;
    mem_pkg::mem_op_e       d1_req_op;
    logic [`MEM_ADDR_W-1:0] d1_req_addr;
    logic [`MEM_DATA_W-1:0] d1_req_wdata;
    logic                   d1_addr_ok;
    logic                   d1_data_ok;
    logic [`MEM_DATA_W-1:0] d1_data;
    logic                   d2_req_valid;
    mem_pkg::mem_op_e       d2_req_op;
    logic [`MEM_ADDR_W-1:0] d2_req_addr;
    logic [`MEM_DATA_W-1:0] d2_req_wdata;
    logic                   d2_addr_ok;
    logic                   d2_data_ok;
    logic [`MEM_DATA_W-1:0] d2_data;
    logic                   creq_valid;
    mem_pkg::mem_op_e       creq_op;
    logic [`MEM_ADDR_W-1:0] creq_addr;
    logic [`MEM_DATA_W-1:0] creq_wdata;
    logic                   cresp_ready;
    logic [`MEM_DATA_W-1:0] cresp_data;
    int                     read_count;

    int                     cycles;
    string                  test_name;
    logic [`MEM_DATA_W-1:0] shadow [logic [`MEM_ADDR_W-1:0]];
    logic [`MEM_DATA_W-1:0] exp_q [3][$];
    bit                     rd_q [3][$];
    int                     dok_cycle [3];
    int                     acc_cycle [3];

    mem_subsys mem_subsys_i (.*);

    cbus_mem_model #(.LATENCY(3)) mem_i (
        .clk, .resetn, .creq_valid, .creq_op, .creq_addr, .creq_wdata,
        .cresp_ready, .cresp_data, .read_count
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [`MEM_ADDR_W-1:0] phys_addr(input logic [`MEM_ADDR_W-1:0] va);
        return {3'b000, va[`MEM_ADDR_W-4:0]};
    endfunction

    // memory content as seen by a read of physical address pa
    function automatic logic [`MEM_DATA_W-1:0] expected_read(input logic [`MEM_ADDR_W-1:0] pa);
        if (shadow.exists(pa))
            return shadow[pa];
        return pa ^ {pa[15:0], pa[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    task automatic check_word(input string what, input logic [`MEM_DATA_W-1:0] exp,
                              input logic [`MEM_DATA_W-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s (%s): expected %h actual %h", test_name, what, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("CHECK FAILED %s (%s): expected %0d actual %0d", test_name, what, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    // data_ok of the earlier request first, then a new acceptance
    task automatic track_port(input int p, input bit acc, input bit is_rd,
                              input logic [`MEM_ADDR_W-1:0] va,
                              input logic [`MEM_DATA_W-1:0] wdata,
                              input bit dok, input logic [`MEM_DATA_W-1:0] rdata);
        logic [`MEM_DATA_W-1:0] exp;
        bit                     was_rd;
        if (dok) begin
            if (exp_q[p].size() == 0) begin
                $display("port %0d returned data_ok with no request outstanding", p);
                $display("Simulation finished: FAIL");
                $fatal(1, "spurious data_ok");
            end
            exp = exp_q[p].pop_front();
            was_rd = rd_q[p].pop_front();
            // data_ok is due in the cycle right after acceptance
            check_count($sformatf("port %0d data_ok latency", p), acc_cycle[p] + 1, cycles);
            dok_cycle[p] = cycles;
            if (was_rd)
                check_word($sformatf("port %0d read", p), exp, rdata);
        end
        if (acc) begin
            if (is_rd) begin
                exp_q[p].push_back(expected_read(phys_addr(va)));
            end else begin
                shadow[phys_addr(va)] = wdata;
                exp_q[p].push_back('0);
            end
            rd_q[p].push_back(is_rd);
            acc_cycle[p] = cycles;
        end
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            track_port(0, ireq_valid && iresp_addr_ok, 1'b1, ireq_addr, '0,
                       iresp_data_ok, iresp_data);
            track_port(1, d1_req_valid && d1_addr_ok, d1_req_op == mem_pkg::OP_READ,
                       d1_req_addr, d1_req_wdata, d1_data_ok, d1_data);
            track_port(2, d2_req_valid && d2_addr_ok, d2_req_op == mem_pkg::OP_READ,
                       d2_req_addr, d2_req_wdata, d2_data_ok, d2_data);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic fetch(input logic [`MEM_ADDR_W-1:0] addr);
        @(negedge clk);
        ireq_valid = 1'b1;
        ireq_addr = addr;
        do @(posedge clk); while (!iresp_addr_ok);
        @(negedge clk);
        ireq_valid = 1'b0;
    endtask

    task automatic data_access(input int p, input mem_pkg::mem_op_e op,
                               input logic [`MEM_ADDR_W-1:0] addr,
                               input logic [`MEM_DATA_W-1:0] wdata);
        @(negedge clk);
        if (p == 1) begin
            d1_req_valid = 1'b1;
            d1_req_op = op;
            d1_req_addr = addr;
            d1_req_wdata = wdata;
        end else begin
            d2_req_valid = 1'b1;
            d2_req_op = op;
            d2_req_addr = addr;
            d2_req_wdata = wdata;
        end
        do @(posedge clk); while (!(p == 1 ? d1_addr_ok : d2_addr_ok));
        @(negedge clk);
        if (p == 1)
            d1_req_valid = 1'b0;
        else
            d2_req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        do @(posedge clk); while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0);
        @(negedge clk);
    endtask

    // cached words at 0x1000, uncached at 0x2000, top two bits random
    function automatic logic [`MEM_ADDR_W-1:0] random_addr(input bit unc);
        logic [`MEM_ADDR_W-1:0] a;
        if (unc)
            a = 32'h0000_2000 + ($urandom_range(0, 15) << 2);
        else
            a = 32'h0000_1000 + ($urandom_range(0, 31) << 2);
        a[31:30] = 2'($urandom_range(0, 3));
        a[`UNCACHE_BIT] = unc;
        return a;
    endfunction

    task automatic random_data_port(input int p);
        bit unc;
        mem_pkg::mem_op_e op;
        repeat (MIX_ACCESSES) begin
            unc = ($urandom_range(0, 2) == 0);
            op = mem_pkg::mem_op_e'($urandom_range(0, 2) == 0);
            data_access(p, op, random_addr(unc), $urandom);
        end
    endtask

    initial begin
        int c0;
        int activity;
        void'($urandom(32'h1500_c49a));
        cycles = 0;
        resetn = 1'b1;
        ireq_valid = 1'b0;
        ireq_addr = '0;
        d1_req_valid = 1'b0;
        d1_req_op = mem_pkg::OP_READ;
        d1_req_addr = '0;
        d1_req_wdata = '0;
        d2_req_valid = 1'b0;
        d2_req_op = mem_pkg::OP_READ;
        d2_req_addr = '0;
        d2_req_wdata = '0;
        repeat (8) @(negedge clk);
        resetn = 1'b0;

        test_name = "idle after reset";
        activity = 0;
        repeat (6) begin
            @(posedge clk);
            activity += iresp_addr_ok + iresp_data_ok + d1_addr_ok + d1_data_ok
                      + d2_addr_ok + d2_data_ok + creq_valid;
        end
        check_count("strobes seen", 0, activity);

        test_name = "instruction fetch";
        c0 = read_count;
        fetch(32'h8000_0010);
        wait_drained();
        check_count("miss reads", c0 + 1, read_count);
        fetch(32'h8000_0010);
        wait_drained();
        check_count("hit reads", c0 + 1, read_count);

        test_name = "write through and alias";
        data_access(1, mem_pkg::OP_WRITE, 32'h0000_1040, 32'hdead_beef);
        data_access(1, mem_pkg::OP_READ, 32'h0000_1040, '0);
        data_access(2, mem_pkg::OP_READ, 32'h2000_1040, '0);
        wait_drained();

        test_name = "two cached reads";
        fork
            data_access(1, mem_pkg::OP_READ, 32'h0000_1008, '0);
            data_access(2, mem_pkg::OP_READ, 32'h0000_100c, '0);
        join
        wait_drained();
        check_count("port 2 after port 1", 1, int'(dok_cycle[2] > dok_cycle[1]));

        test_name = "uncached repeat";
        repeat (4) begin
            c0 = read_count;
            data_access(1, mem_pkg::OP_READ, 32'h2000_2008, '0);
            wait_drained();
            check_count("reads per access", c0 + 1, read_count);
        end

        test_name = "random mix";
        fork
            random_data_port(1);
            random_data_port(2);
            repeat (MIX_ACCESSES) fetch(32'h0000_0000 + ($urandom_range(0, 31) << 2));
        join
        wait_drained();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// one word per line, so lines == words
`define ICACHE_LINES 16
`define DCACHE_LINES 16

// virtual address bit that selects the uncached path
`define UNCACHE_BIT 29

`endif

// ==== src.f ====
+incdir+include
design/mem_pkg.sv
design/icache.sv
design/dcache.sv
design/uncache_bridge.sv
design/cbus_arbiter.sv
design/cache_manage.sv
design/mem_subsys.sv
dv/cbus_mem_model.sv
dv/tb_mem_subsys.sv
